// File: hdl/exec_pkg.sv
`default_nettype none

package exec_pkg;

	// number of physical registers behind the bus
	parameter int PRF_SIZE = 64;

	typedef logic [$clog2(PRF_SIZE)-1:0] tag_t;

	typedef logic [63:0] word_t;

	typedef enum logic [1:0]
	{
		op_add,
		op_sub,
		op_mul,
		op_mem
	} op_t;

	// operands travel with the operation, nothing is read from the register file
	typedef struct packed
	{
		op_t   op;
		// only looked at for op_mem
		logic  is_store;
		// for memory operations this is the address
		word_t a;
		// for stores this is the data written
		word_t b;
		tag_t  dest;
	} issue_t;

	// what a unit hands to the common data bus
	typedef struct packed
	{
		word_t value;
		tag_t  tag;
	} result_t;

endpackage

`default_nettype wire

// File: hdl/issue_router.sv
`timescale 1ns/1ns
`default_nettype none

module issue_router import exec_pkg::*;
(
	input  wire    clock,
	input  wire    rst_n,
	input  wire    issue_req,
	input  wire    issue_t issue_pkt,
	output logic   issue_ack,
	input  wire    add_busy,
	input  wire    mul_busy,
	input  wire    mem_busy,
	output logic   add_start,
	output logic   mul_start,
	output logic   mem_start,
	output issue_t unit_pkt
);

	typedef enum logic {s_idle, s_ack} state_t;

	state_t     state;
	logic       tgt_busy;
	logic [2:0] sel_d;
	logic [2:0] unit_sel;
	logic       go;
	logic       start_q;

	// one-hot target as {memory, multiplier, adder}
	always_comb
	begin
		case (issue_pkt.op)
			op_add, op_sub:
			begin
				tgt_busy = add_busy;
				sel_d    = 3'b001;
			end
			op_mul:
			begin
				tgt_busy = mul_busy;
				sel_d    = 3'b010;
			end
			default:
			begin
				tgt_busy = mem_busy;
				sel_d    = 3'b100;
			end
		endcase
	end

	assign go = (state == s_idle) && issue_req && !tgt_busy;

	always_ff @(posedge clock or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state     <= s_idle;
			issue_ack <= 1'b0;
			start_q   <= 1'b0;
			unit_sel  <= '0;
		end
		else
		begin
			// start fires once, in the first cycle that ack is high
			start_q <= go;
			if (go)
			begin
				state     <= s_ack;
				issue_ack <= 1'b1;
				unit_sel  <= sel_d;
			end
			else if (state == s_ack && !issue_req)
			begin
				state     <= s_idle;
				issue_ack <= 1'b0;
			end
		end
	end

	always_ff @(posedge clock)
	begin
		if (go)
			unit_pkt <= issue_pkt;
	end

	assign add_start = start_q && unit_sel[0];
	assign mul_start = start_q && unit_sel[1];
	assign mem_start = start_q && unit_sel[2];

endmodule

`default_nettype wire

// File: hdl/adder_unit.sv
`timescale 1ns/1ns
`default_nettype none

module adder_unit import exec_pkg::*;
(
	input  wire     clock,
	input  wire     rst_n,
	input  wire     start,
	input  wire     issue_t pkt,
	input  wire     send_fail,
	output logic    busy,
	output logic    ready,
	output result_t res
);

	always_ff @(posedge clock or negedge rst_n)
	begin
		if (!rst_n)
		begin
			ready <= 1'b0;
		end
		else if (start)
		begin
			ready <= 1'b1;
		end
		else if (!send_fail)
		begin
			// a ready result with no fail back was taken by the bus this cycle
			ready <= 1'b0;
		end
	end

	always_ff @(posedge clock)
	begin
		if (start)
		begin
			res.tag <= pkt.dest;
			if (pkt.op == op_sub)
				res.value <= pkt.a - pkt.b;
			else
				res.value <= pkt.a + pkt.b;
		end
	end

	// the router must not start a new add while the old result waits for the bus
	assign busy = ready;

endmodule

`default_nettype wire

// File: hdl/mult_unit.sv
`timescale 1ns/1ns
`default_nettype none

module mult_unit import exec_pkg::*;
(
	input  wire     clock,
	input  wire     rst_n,
	input  wire     start,
	input  wire     issue_t pkt,
	input  wire     send_fail,
	output logic    busy,
	output logic    ready,
	output result_t res
);

	logic    s1_valid;
	logic    s2_valid;
	logic    s3_valid;
	logic    s4_valid;
	issue_t  s1_pkt;
	result_t s2_res;
	result_t s3_res;
	result_t s4_res;
	logic    s1_open;
	logic    s2_open;
	logic    s3_open;
	logic    s4_open;

	// a stage can take new data when it is empty or when its content moves on
	assign s4_open = !s4_valid || !send_fail;
	assign s3_open = !s3_valid || s4_open;
	assign s2_open = !s2_valid || s3_open;
	assign s1_open = !s1_valid || s2_open;

	always_ff @(posedge clock or negedge rst_n)
	begin
		if (!rst_n)
		begin
			s1_valid <= 1'b0;
			s2_valid <= 1'b0;
			s3_valid <= 1'b0;
			s4_valid <= 1'b0;
		end
		else
		begin
			if (s4_open)
				s4_valid <= s3_valid;
			if (s3_open)
				s3_valid <= s2_valid;
			if (s2_open)
				s2_valid <= s1_valid;
			if (s1_open)
				s1_valid <= start;
		end
	end

	always_ff @(posedge clock)
	begin
		if (s1_open && start)
			s1_pkt <= pkt;
		if (s2_open)
		begin
			// only the low 64 bits of the product are kept
			s2_res.value <= s1_pkt.a * s1_pkt.b;
			s2_res.tag   <= s1_pkt.dest;
		end
		if (s3_open)
			s3_res <= s2_res;
		if (s4_open)
			s4_res <= s3_res;
	end

	assign busy  = !s1_open;
	assign ready = s4_valid;
	assign res   = s4_res;

endmodule

`default_nettype wire

// File: hdl/memory_unit.sv
`timescale 1ns/1ns
`default_nettype none

module memory_unit import exec_pkg::*;
#(
	parameter int mem_words = 16
)
(
	input  wire     clock,
	input  wire     rst_n,
	input  wire     start,
	input  wire     issue_t pkt,
	output logic    ready,
	output result_t res,
	output logic    busy
);

	localparam int addr_w = $clog2(mem_words);

	word_t             mem [mem_words];
	logic              s1_valid;
	logic              s1_store;
	logic [addr_w-1:0] s1_addr;
	word_t             s1_data;
	tag_t              s1_tag;
	logic              s2_valid;
	logic              s2_store;
	logic [addr_w-1:0] s2_addr;
	word_t             s2_data;
	tag_t              s2_tag;

	// the bus always takes memory results first, so nothing here ever waits
	always_ff @(posedge clock or negedge rst_n)
	begin
		if (!rst_n)
		begin
			s1_valid <= 1'b0;
			s2_valid <= 1'b0;
		end
		else
		begin
			s1_valid <= start;
			s2_valid <= s1_valid;
		end
	end

	always_ff @(posedge clock)
	begin
		if (start)
		begin
			s1_store <= pkt.is_store;
			s1_addr  <= pkt.a[addr_w-1:0];
			s1_data  <= pkt.b;
			s1_tag   <= pkt.dest;
		end
		s2_store <= s1_store;
		s2_addr  <= s1_addr;
		s2_data  <= s1_data;
		s2_tag   <= s1_tag;
		if (s2_valid && s2_store)
			mem[s2_addr] <= s2_data;
	end

	// loads read the store combinationally in stage two, so a load right
	// behind a store to the same word sees the new data
	assign res.value = mem[s2_addr];
	assign res.tag   = s2_tag;
	assign ready     = s2_valid && !s2_store;
	assign busy      = s1_valid && s2_valid;

endmodule

`default_nettype wire

// File: hdl/cdb.sv
`timescale 1ns/1ns
`default_nettype none

module cdb import exec_pkg::*;
(
	input  wire     adder_ready,
	input  wire     mult_ready,
	input  wire     memory_ready,
	input  wire     result_t adder_res,
	input  wire     result_t mult_res,
	input  wire     result_t memory_res,
	output logic    cdb_valid,
	output result_t cdb_res,
	output logic    mult_send_fail,
	output logic    adder_send_fail
);

	always_comb
	begin
		casez ({memory_ready, mult_ready, adder_ready})
			3'b1??:
			begin
				cdb_valid       = 1'b1;
				cdb_res         = memory_res;
				mult_send_fail  = mult_ready;
				adder_send_fail = adder_ready;
			end
			3'b01?:
			begin
				cdb_valid       = 1'b1;
				cdb_res         = mult_res;
				mult_send_fail  = 1'b0;
				adder_send_fail = adder_ready;
			end
			3'b001:
			begin
				cdb_valid       = 1'b1;
				cdb_res         = adder_res;
				mult_send_fail  = 1'b0;
				adder_send_fail = 1'b0;
			end
			default:
			begin
				// bus idle, drive zeros so nothing stale shows on the tag lines
				cdb_valid       = 1'b0;
				cdb_res         = '0;
				mult_send_fail  = 1'b0;
				adder_send_fail = 1'b0;
			end
		endcase
	end

endmodule

`default_nettype wire

// File: hdl/phys_reg_file.sv
`timescale 1ns/1ns
`default_nettype none

module phys_reg_file import exec_pkg::*;
#(
	parameter int prf_size = PRF_SIZE
)
(
	input  wire     clock,
	input  wire     rst_n,
	input  wire     alloc,
	input  wire     tag_t alloc_tag,
	input  wire     cdb_valid,
	input  wire     result_t cdb_res,
	input  wire     tag_t rd_tag,
	output word_t   rd_data,
	output logic    rd_valid
);

	word_t               regs [prf_size];
	logic [prf_size-1:0] valid;

	always_ff @(posedge clock or negedge rst_n)
	begin
		if (!rst_n)
		begin
			valid <= '0;
		end
		else
		begin
			if (alloc)
				valid[alloc_tag] <= 1'b0;
			// the broadcast comes second so it wins on a shared tag
			if (cdb_valid)
				valid[cdb_res.tag] <= 1'b1;
		end
	end

	always_ff @(posedge clock)
	begin
		if (cdb_valid)
			regs[cdb_res.tag] <= cdb_res.value;
	end

	assign rd_data  = regs[rd_tag];
	assign rd_valid = valid[rd_tag];

endmodule

`default_nettype wire

// File: hdl/exec_writeback.sv
`timescale 1ns/1ns
`default_nettype none

module exec_writeback import exec_pkg::*;
#(
	parameter int prf_size  = PRF_SIZE,
	parameter int mem_words = 16
)
(
	input  wire     clock,
	input  wire     rst_n,
	input  wire     issue_req,
	input  wire     issue_t issue_pkt,
	output logic    issue_ack,
	output logic    cdb_valid,
	output result_t cdb_res,
	input  wire     tag_t rd_tag,
	output word_t   rd_data,
	output logic    rd_valid
);

	issue_t  unit_pkt;
	logic    add_start, mul_start, mem_start;
	logic    add_busy, mul_busy, mem_busy;
	logic    add_ready, mul_ready, mem_ready;
	result_t add_res, mul_res, mem_res;
	logic    add_fail, mul_fail;
	logic    ack_q;

	// the destination is claimed on the first cycle of ack
	always_ff @(posedge clock or negedge rst_n)
	begin
		if (!rst_n)
			ack_q <= 1'b0;
		else
			ack_q <= issue_ack;
	end

	issue_router i_issue_router (.clock, .rst_n, .issue_req, .issue_pkt, .issue_ack,
		.add_busy, .mul_busy, .mem_busy, .add_start, .mul_start, .mem_start, .unit_pkt);

	adder_unit i_adder_unit (.clock, .rst_n, .start(add_start), .pkt(unit_pkt),
		.send_fail(add_fail), .busy(add_busy), .ready(add_ready), .res(add_res));

	mult_unit i_mult_unit (.clock, .rst_n, .start(mul_start), .pkt(unit_pkt),
		.send_fail(mul_fail), .busy(mul_busy), .ready(mul_ready), .res(mul_res));

	memory_unit #(.mem_words(mem_words)) i_memory_unit (.clock, .rst_n, .start(mem_start),
		.pkt(unit_pkt), .ready(mem_ready), .res(mem_res), .busy(mem_busy));

	cdb i_cdb (.adder_ready(add_ready), .mult_ready(mul_ready), .memory_ready(mem_ready),
		.adder_res(add_res), .mult_res(mul_res), .memory_res(mem_res), .cdb_valid,
		.cdb_res, .mult_send_fail(mul_fail), .adder_send_fail(add_fail));

	phys_reg_file #(.prf_size(prf_size)) i_phys_reg_file (.clock, .rst_n,
		.alloc(issue_ack && !ack_q), .alloc_tag(unit_pkt.dest), .cdb_valid, .cdb_res,
		.rd_tag, .rd_data, .rd_valid);

endmodule

`default_nettype wire

// File: testbench/tb_exec_writeback.sv
`timescale 1ns/1ns
`default_nettype none

module tb_exec_writeback import exec_pkg::*;
	;

	localparam int reset_cycles = 5;
	localparam int random_ops   = 60;
	// operations over all tests, the watchdog allows 40 cycles for each
	localparam int num_ops      = 6 + 4 + 2 + 12 + 16 + random_ops;
	localparam int ack_bound    = 50;
	localparam int valid_bound  = 60;

	logic    clock;
	logic    rst_n;
	logic    issue_req;
	issue_t  issue_pkt;
	logic    issue_ack;
	logic    cdb_valid;
	result_t cdb_res;
	tag_t    rd_tag;
	word_t   rd_data;
	logic    rd_valid;

	logic [31:0] lfsr_state;
	int          bcast_count [PRF_SIZE];
	int          bcast_cycle [PRF_SIZE];
	word_t       bcast_value [PRF_SIZE];
	int          cycle_count;

	exec_writeback #(.prf_size(PRF_SIZE), .mem_words(16)) i_exec_writeback (.clock, .rst_n,
		.issue_req, .issue_pkt, .issue_ack, .cdb_valid, .cdb_res, .rd_tag, .rd_data, .rd_valid);

	initial
	begin
		clock = 1'b0;
		forever
			#2 clock = ~clock;
	end

	initial
	begin
		repeat (reset_cycles + num_ops * 40)
			@(posedge clock);
		$display("timeout: the tests did not finish in the allowed number of cycles");
		$display("TEST FAILED");
		$fatal(1);
	end

	task automatic stop_run(input string msg);
		$display("%s", msg);
		$display("TEST FAILED");
		$fatal(1);
	endtask

	task automatic check_eq(input string name, input logic [63:0] got, input logic [63:0] exp);
		if (got !== exp)
		begin
			$display("ERROR %s: got 0x%h, expected 0x%h", name, got, exp);
			$display("TEST FAILED");
			$fatal(1);
		end
	endtask

	// every broadcast is counted per tag, together with its cycle and value
	always @(negedge clock)
	begin
		cycle_count++;
		if (rst_n && cdb_valid)
		begin
			bcast_count[cdb_res.tag]++;
			bcast_cycle[cdb_res.tag] = cycle_count;
			bcast_value[cdb_res.tag] = cdb_res.value;
		end
	end

	// 32-bit Galois LFSR, one step for every bit handed out
	function automatic logic [63:0] random_bits(input int n);
		logic [63:0] v;
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			v = {v[62:0], lfsr_state[0]};
			if (lfsr_state[0])
				lfsr_state = (lfsr_state >> 1) ^ 32'h80200003;
			else
				lfsr_state = lfsr_state >> 1;
		end
		return v;
	endfunction

	function automatic word_t alu_model(input op_t op, input word_t a, input word_t b);
		logic [127:0] product;
		product = {64'd0, a} * {64'd0, b};
		case (op)
			op_add:  return a + b;
			op_sub:  return a - b;
			default: return product[63:0];
		endcase
	endfunction

	function automatic issue_t make_op(input op_t op, input logic st, input word_t a,
		input word_t b, input int dest);
		issue_t p;
		p.op       = op;
		p.is_store = st;
		p.a        = a;
		p.b        = b;
		p.dest     = tag_t'(dest);
		return p;
	endfunction

	task automatic next_cycle();
		@(posedge clock);
		#1;
	endtask

	task automatic clear_broadcasts();
		foreach (bcast_count[i])
			bcast_count[i] = 0;
	endtask

	// one full four-phase handshake
	task automatic issue(input issue_t pkt);
		int cycles;
		issue_pkt = pkt;
		issue_req = 1'b1;
		cycles = 0;
		do
		begin
			next_cycle();
			cycles++;
		end
		while (!issue_ack && cycles < ack_bound);
		if (!issue_ack)
			stop_run("the issue port never raised ack for a request");
		issue_req = 1'b0;
		cycles = 0;
		do
		begin
			next_cycle();
			cycles++;
		end
		while (issue_ack && cycles < ack_bound);
		if (issue_ack)
			stop_run("the issue port kept ack high after the request dropped");
	endtask

	task automatic wait_valid(input int tag);
		int cycles;
		rd_tag = tag_t'(tag);
		cycles = 0;
		do
		begin
			next_cycle();
			cycles++;
		end
		while (!rd_valid && cycles < valid_bound);
		if (!rd_valid)
			stop_run($sformatf("register %0d never became valid", tag));
	endtask

	task automatic check_register(input int tag, input word_t exp);
		wait_valid(tag);
		check_eq($sformatf("rd_data[%0d]", tag), rd_data, exp);
		check_eq($sformatf("broadcasts of tag %0d", tag), bcast_count[tag], 1);
		check_eq($sformatf("cdb_res.value for tag %0d", tag), bcast_value[tag], exp);
	endtask

	// a store claims its tag but must never be broadcast
	task automatic check_store_tag(input int tag);
		rd_tag = tag_t'(tag);
		#1;
		check_eq($sformatf("rd_valid[%0d]", tag), rd_valid, 1'b0);
		check_eq($sformatf("broadcasts of tag %0d", tag), bcast_count[tag], 0);
		next_cycle();
	endtask

	task automatic test_reset_state();
		check_eq("issue_ack", issue_ack, 1'b0);
		check_eq("cdb_valid", cdb_valid, 1'b0);
		for (int t = 0; t < PRF_SIZE; t++)
		begin
			rd_tag = tag_t'(t);
			#1;
			check_eq($sformatf("rd_valid[%0d]", t), rd_valid, 1'b0);
			next_cycle();
		end
	endtask

	task automatic test_add_sub();
		issue_t p [6];
		clear_broadcasts();
		p[0] = make_op(op_add, 1'b0, '1, 64'd1, 1);
		p[1] = make_op(op_sub, 1'b0, 64'd0, 64'd1, 2);
		for (int i = 2; i < 6; i++)
			p[i] = make_op(i % 2 ? op_sub : op_add, 1'b0, random_bits(64), random_bits(64), i + 1);
		foreach (p[i])
			issue(p[i]);
		foreach (p[i])
			check_register(p[i].dest, alu_model(p[i].op, p[i].a, p[i].b));
	endtask

	task automatic test_mul_burst();
		issue_t p [4];
		clear_broadcasts();
		foreach (p[i])
			p[i] = make_op(op_mul, 1'b0, random_bits(64), random_bits(64), 10 + i);
		foreach (p[i])
			issue(p[i]);
		foreach (p[i])
			check_register(p[i].dest, alu_model(op_mul, p[i].a, p[i].b));
	endtask

	task automatic test_store_load();
		word_t data;
		clear_broadcasts();
		data = random_bits(64);
		issue(make_op(op_mem, 1'b1, 64'd5, data, 20));
		issue(make_op(op_mem, 1'b0, 64'd5, 64'd0, 21));
		check_register(21, data);
		check_store_tag(20);
	endtask

	task automatic test_collisions();
		word_t  stored [3];
		issue_t mul_op;
		clear_broadcasts();
		foreach (stored[k])
		begin
			stored[k] = random_bits(64);
			issue(make_op(op_mem, 1'b1, word_t'(k + 1), stored[k], 40 + k));
		end
		// a load issued right behind a multiply becomes ready in the same cycle
		for (int k = 0; k < 3; k++)
		begin
			issue(make_op(op_mul, 1'b0, 64'd1000 + k, 64'd77 + k, 43 + 3 * k));
			issue(make_op(op_mem, 1'b0, word_t'(k + 1), 64'd0, 44 + 3 * k));
			issue(make_op(op_add, 1'b0, 64'd5 + k, 64'd9, 45 + 3 * k));
		end
		for (int k = 0; k < 3; k++)
		begin
			mul_op = make_op(op_mul, 1'b0, 64'd1000 + k, 64'd77 + k, 0);
			check_register(43 + 3 * k, alu_model(op_mul, mul_op.a, mul_op.b));
			check_register(44 + 3 * k, stored[k]);
			check_register(45 + 3 * k, alu_model(op_add, 64'd5 + k, 64'd9));
		end
		// the load takes the shared cycle and the held multiply follows right after
		for (int k = 0; k < 3; k++)
			check_eq($sformatf("cycles from load %0d to multiply %0d broadcast",
				44 + 3 * k, 43 + 3 * k), bcast_cycle[43 + 3 * k] - bcast_cycle[44 + 3 * k], 1);
		for (int k = 0; k < 3; k++)
			check_store_tag(40 + k);
	endtask

	task automatic test_random_mix();
		word_t      mem_model [16];
		word_t      expect_val [random_ops];
		logic       is_st [random_ops];
		op_t        op;
		logic [3:0] addr;
		word_t      a;
		word_t      b;
		clear_broadcasts();
		for (int i = 0; i < 16; i++)
		begin
			mem_model[i] = random_bits(64);
			issue(make_op(op_mem, 1'b1, word_t'(i), mem_model[i], 63));
		end
		for (int i = 0; i < random_ops; i++)
		begin
			op = op_t'(random_bits(2));
			is_st[i] = 1'b0;
			if (op == op_mem)
			begin
				is_st[i] = random_bits(1);
				addr = random_bits(4);
				b = random_bits(64);
				issue(make_op(op_mem, is_st[i], word_t'(addr), b, i));
				if (is_st[i])
					mem_model[addr] = b;
				else
					expect_val[i] = mem_model[addr];
			end
			else
			begin
				a = random_bits(64);
				b = random_bits(64);
				issue(make_op(op, 1'b0, a, b, i));
				expect_val[i] = alu_model(op, a, b);
			end
		end
		for (int i = 0; i < random_ops; i++)
			if (!is_st[i])
				check_register(i, expect_val[i]);
		for (int i = 0; i < random_ops; i++)
			if (is_st[i])
				check_store_tag(i);
	endtask

	initial
	begin
		rst_n       = 1'b0;
		issue_req   = 1'b0;
		issue_pkt   = '0;
		rd_tag      = '0;
		lfsr_state  = 32'd72;
		cycle_count = 0;
		clear_broadcasts();
		repeat (reset_cycles)
			@(posedge clock);
		#1;
		rst_n = 1'b1;
		next_cycle();
		test_reset_state();
		test_add_sub();
		test_mul_burst();
		test_store_load();
		test_collisions();
		test_random_mix();
		$display("TEST OK");
		$finish;
	end

endmodule

`default_nettype wire

// File: exec_writeback.f
hdl/exec_pkg.sv
hdl/issue_router.sv
hdl/adder_unit.sv
hdl/mult_unit.sv
hdl/memory_unit.sv
hdl/cdb.sv
hdl/phys_reg_file.sv
hdl/exec_writeback.sv
testbench/tb_exec_writeback.sv
